//--- verilog/dac_config.svh
`ifndef DAC_CONFIG_SVH
`define DAC_CONFIG_SVH

// ####################
// Sizes
// ####################
`define DATA_WIDTH 16
`define BATCH_SIZE 8
`define MEM_SIZE 16
`define DMA_DATA_WIDTH 48

// ####################
// Command word ids
// ####################
`define PS_SEED_BASE_ID 0
`define PS_SEED_VALID_ID 8 // One past the last seed word
`define TRIG_WAVE_ID 9
`define RUN_PWL_ID 10

`endif

//--- verilog/dac_types_pkg.sv
`include "dac_config.svh"

package dac_types_pkg;

	// One DAC sample
	typedef logic [`DATA_WIDTH-1:0] sample_t;

	// Lane 0 sits in the low bits
	typedef logic [`BATCH_SIZE*`DATA_WIDTH-1:0] batch_t;

	// Index of a command word
	typedef logic [$clog2(`MEM_SIZE)-1:0] mem_id_t;

	// Right shift applied to every lane
	typedef logic [$clog2(`DATA_WIDTH)-1:0] scale_t;

	// start / slope / length, high to low
	typedef logic [`DMA_DATA_WIDTH-1:0] dma_word_t;

endpackage

//--- verilog/dac_mode_pkg.sv
package dac_mode_pkg;

	typedef enum logic [1:0] {
		MODE_IDLE,
		MODE_RAND,
		MODE_TRIG,
		MODE_PWL
	} wave_mode_e;

	typedef enum logic [1:0] {
		PWL_IDLE,
		PWL_LOAD, // Waiting on a DMA word
		PWL_RUN,
		PWL_DONE
	} pwl_state_e;

endpackage

//--- verilog/dac_cmd_decoder.sv
`include "dac_config.svh"

module dac_cmd_decoder
	import dac_types_pkg::*;
	import dac_mode_pkg::*;
(
	input  logic                      dac_clk,
	input  logic                      rst,
	input  logic [`MEM_SIZE-1:0]      fresh_bits,
	input  sample_t [`MEM_SIZE-1:0]   read_resps,
	input  logic                      halt,
	input  logic                      pwl_done,
	output logic                      dac_intf_rdy,
	output wave_mode_e                mode,
	output batch_t                    seeds,
	output logic                      load_seeds,
	output logic                      trig_restart,
	output logic                      pwl_start
);
	localparam int SEED_COUNT = `PS_SEED_VALID_ID - `PS_SEED_BASE_ID;
	localparam int SEED_IDX_W = $clog2(`BATCH_SIZE);
	localparam mem_id_t SEED_BASE = mem_id_t'(`PS_SEED_BASE_ID);
	localparam mem_id_t SEED_VALID = mem_id_t'(`PS_SEED_VALID_ID);
	localparam mem_id_t TRIG_ID = mem_id_t'(`TRIG_WAVE_ID);
	localparam mem_id_t PWL_ID = mem_id_t'(`RUN_PWL_ID);

	logic scan_hit;
	mem_id_t scan_id;
	logic take;
	logic req_valid;
	mem_id_t req_id;
	sample_t req_data;
	mem_id_t seed_lane;
	sample_t [`BATCH_SIZE-1:0] seed_regs;

	// Lowest set flag wins
	always_comb begin
		scan_hit = 1'b0;
		scan_id = '0;
		for (int i = `MEM_SIZE - 1; i >= 0; i--) begin
			if (fresh_bits[i]) begin
				scan_hit = 1'b1;
				scan_id = mem_id_t'(i);
			end
		end
	end

	// Flag stays high until the ack edge, so skip it while busy
	assign take = scan_hit && !req_valid && !dac_intf_rdy;

	always_ff @(posedge dac_clk) begin
		if (rst) begin
			req_valid <= 1'b0;
		end else begin
			req_valid <= take;
		end
	end

	always_ff @(posedge dac_clk) begin
		if (take) begin
			req_id <= scan_id;
			req_data <= read_resps[scan_id];
		end
	end

	// ####################
	// Decode
	// ####################
	always_ff @(posedge dac_clk) begin
		if (rst) begin
			dac_intf_rdy <= 1'b0;
			mode <= MODE_IDLE;
			load_seeds <= 1'b0;
			trig_restart <= 1'b0;
			pwl_start <= 1'b0;
		end else begin
			dac_intf_rdy <= req_valid;
			load_seeds <= 1'b0;
			trig_restart <= 1'b0;
			pwl_start <= 1'b0;
			if (pwl_done && mode == MODE_PWL) mode <= MODE_IDLE;
			if (req_valid && !halt) begin
				case (req_id)
					SEED_VALID: begin
						if (req_data == sample_t'(1)) begin
							load_seeds <= 1'b1;
							mode <= MODE_RAND;
						end
					end
					TRIG_ID: begin
						trig_restart <= 1'b1;
						mode <= MODE_TRIG;
					end
					PWL_ID: begin
						pwl_start <= 1'b1;
						mode <= MODE_PWL;
					end
					default: ;
				endcase
			end
			if (halt) mode <= MODE_IDLE; // Halt beats any command
		end
	end

	// Ids below the base wrap to a large lane and miss the range check
	assign seed_lane = req_id - SEED_BASE;

	always_ff @(posedge dac_clk) begin
		if (req_valid && seed_lane < mem_id_t'(SEED_COUNT)) begin
			seed_regs[seed_lane[SEED_IDX_W-1:0]] <= req_data;
		end
	end

	assign seeds = seed_regs;

	a_rdy_single: assert property (@(posedge dac_clk) disable iff (rst)
		dac_intf_rdy |=> !dac_intf_rdy);

endmodule

//--- verilog/rand_batch_gen.sv
`include "dac_config.svh"

module rand_batch_gen
	import dac_types_pkg::*;
(
	input  logic   dac_clk,
	input  logic   rst,
	input  batch_t seeds,
	input  logic   load_seeds,
	output logic   gen_valid,
	input  logic   gen_ready,
	output batch_t batch
);
	localparam sample_t TAP_MASK = 16'hB400;

	sample_t [`BATCH_SIZE-1:0] seed_words;
	sample_t [`BATCH_SIZE-1:0] lanes;

	// Galois form, shifting right
	function automatic sample_t lfsr_step(sample_t s);
		return (s >> 1) ^ (s[0] ? TAP_MASK : '0);
	endfunction

	assign seed_words = seeds;

	always_ff @(posedge dac_clk) begin
		if (rst) begin
			gen_valid <= 1'b0;
		end else if (load_seeds) begin
			gen_valid <= 1'b1;
		end
	end

	always_ff @(posedge dac_clk) begin
		if (load_seeds) begin
			for (int i = 0; i < `BATCH_SIZE; i++) begin
				// All-zero state would lock up
				lanes[i] <= (seed_words[i] == '0) ? sample_t'(1) : seed_words[i];
			end
		end else if (gen_valid && gen_ready) begin
			for (int i = 0; i < `BATCH_SIZE; i++) begin
				lanes[i] <= lfsr_step(lanes[i]);
			end
		end
	end

	assign batch = lanes;

endmodule

//--- verilog/trig_batch_gen.sv
`include "dac_config.svh"

module trig_batch_gen
	import dac_types_pkg::*;
(
	input  logic   dac_clk,
	input  logic   rst,
	input  logic   trig_restart,
	output logic   gen_valid,
	input  logic   gen_ready,
	output batch_t batch
);
	sample_t base;
	sample_t [`BATCH_SIZE-1:0] lanes;

	always_ff @(posedge dac_clk) begin
		if (rst) begin
			gen_valid <= 1'b0;
		end else if (trig_restart) begin
			gen_valid <= 1'b1;
		end
	end

	always_ff @(posedge dac_clk) begin
		if (trig_restart) begin
			base <= '0;
		end else if (gen_valid && gen_ready) begin
			base <= base + sample_t'(`BATCH_SIZE); // Wraps at 2^16
		end
	end

	always_comb begin
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			lanes[i] = base + sample_t'(i);
		end
	end

	assign batch = lanes;

endmodule

//--- verilog/pwl_batch_gen.sv
`include "dac_config.svh"

module pwl_batch_gen
	import dac_types_pkg::*;
	import dac_mode_pkg::*;
(
	input  logic      dac_clk,
	input  logic      rst,
	input  logic      pwl_start,
	input  logic      dma_valid,
	input  dma_word_t dma_data,
	input  logic      dma_last,
	output logic      dma_ready,
	output logic      gen_valid,
	input  logic      gen_ready,
	output batch_t    batch,
	output logic      pwl_done
);
	pwl_state_e state;

	sample_t seg_start;
	sample_t seg_slope;
	sample_t seg_len;
	sample_t cur;
	sample_t slope;
	sample_t remaining; // Batches left in this segment
	logic last_seg;
	sample_t next_cur;
	sample_t [`BATCH_SIZE-1:0] lanes;

	// DMA word fields
	assign seg_start = dma_data[`DMA_DATA_WIDTH-1 -: `DATA_WIDTH];
	assign seg_slope = dma_data[2*`DATA_WIDTH-1 -: `DATA_WIDTH];
	assign seg_len = dma_data[`DATA_WIDTH-1:0];

	assign dma_ready = (state == PWL_LOAD);
	assign gen_valid = (state == PWL_RUN);
	assign pwl_done = (state == PWL_DONE);

	// ####################
	// FSM
	// ####################
	always_ff @(posedge dac_clk) begin
		if (rst) begin
			state <= PWL_IDLE;
		end else if (pwl_start) begin
			state <= PWL_LOAD;
		end else begin
			case (state)
				PWL_LOAD: begin
					if (dma_valid) state <= PWL_RUN;
				end
				PWL_RUN: begin
					if (gen_ready && remaining == sample_t'(1)) begin
						state <= last_seg ? PWL_DONE : PWL_LOAD;
					end
				end
				PWL_DONE: state <= PWL_IDLE; // One-cycle done pulse
				default: state <= PWL_IDLE;
			endcase
		end
	end

	always_ff @(posedge dac_clk) begin
		if (dma_ready && dma_valid) begin
			cur <= seg_start;
			slope <= seg_slope;
			remaining <= (seg_len == '0) ? sample_t'(1) : seg_len;
			last_seg <= dma_last;
		end else if (gen_valid && gen_ready) begin
			cur <= next_cur;
			remaining <= remaining - sample_t'(1);
		end
	end

	// Adder chain, the final sum is the first lane of the next batch
	always_comb begin : lane_calc
		sample_t acc;
		acc = cur;
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			lanes[i] = acc;
			acc = acc + slope; // Signed step, modular add
		end
		next_cur = acc;
	end

	assign batch = lanes;

	// A running segment always has a batch left
	a_run_remaining: assert property (@(posedge dac_clk) disable iff (rst)
		gen_valid |-> (remaining != '0));

endmodule

//--- verilog/batch_output_stage.sv
`include "dac_config.svh"

module batch_output_stage
	import dac_types_pkg::*;
	import dac_mode_pkg::*;
(
	input  logic       dac_clk,
	input  logic       rst,
	input  wave_mode_e mode,
	input  logic       rand_valid,
	output logic       rand_ready,
	input  batch_t     rand_batch,
	input  logic       trig_valid,
	output logic       trig_ready,
	input  batch_t     trig_batch,
	input  logic       pwl_valid,
	output logic       pwl_ready,
	input  batch_t     pwl_batch,
	input  scale_t     scale_factor,
	input  logic       dac0_rdy,
	output batch_t     dac_batch,
	output logic       valid_dac_batch
);
	logic can_load;
	logic sel_valid;
	logic load;
	sample_t [`BATCH_SIZE-1:0] sel_lanes;
	sample_t [`BATCH_SIZE-1:0] scaled_lanes;

	// Free now, or the held batch leaves this edge
	assign can_load = !valid_dac_batch || dac0_rdy;

	assign rand_ready = can_load && (mode == MODE_RAND);
	assign trig_ready = can_load && (mode == MODE_TRIG);
	assign pwl_ready = can_load && (mode == MODE_PWL);

	always_comb begin
		case (mode)
			MODE_RAND: begin
				sel_valid = rand_valid;
				sel_lanes = rand_batch;
			end
			MODE_TRIG: begin
				sel_valid = trig_valid;
				sel_lanes = trig_batch;
			end
			MODE_PWL: begin
				sel_valid = pwl_valid;
				sel_lanes = pwl_batch;
			end
			default: begin
				sel_valid = 1'b0;
				sel_lanes = '0;
			end
		endcase
	end

	assign load = sel_valid && can_load;

	always_comb begin
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			scaled_lanes[i] = sel_lanes[i] >> scale_factor; // Logical shift
		end
	end

	always_ff @(posedge dac_clk) begin
		if (rst) begin
			valid_dac_batch <= 1'b0;
		end else if (load) begin
			valid_dac_batch <= 1'b1;
		end else if (dac0_rdy) begin
			valid_dac_batch <= 1'b0;
		end
	end

	always_ff @(posedge dac_clk) begin
		if (load) dac_batch <= scaled_lanes;
	end

	a_hold_stable: assert property (@(posedge dac_clk) disable iff (rst)
		(valid_dac_batch && !dac0_rdy) |=> (valid_dac_batch && $stable(dac_batch)));

endmodule

//--- verilog/dac_intf.sv
`include "dac_config.svh"

module dac_intf
	import dac_types_pkg::*;
	import dac_mode_pkg::*;
(
	input  logic                    dac_clk,
	input  logic                    rst,
	input  logic [`MEM_SIZE-1:0]    fresh_bits,
	input  sample_t [`MEM_SIZE-1:0] read_resps,
	input  scale_t                  scale_factor,
	input  logic                    halt,
	input  logic                    dac0_rdy,
	input  logic                    dma_valid,
	input  dma_word_t               dma_data,
	input  logic                    dma_last,
	output logic                    dma_ready,
	output logic                    dac_intf_rdy,
	output batch_t                  dac_batch,
	output logic                    valid_dac_batch
);
	wave_mode_e mode;
	batch_t seeds;
	logic load_seeds;
	logic trig_restart;
	logic pwl_start;
	logic pwl_done;

	logic rand_valid;
	logic rand_ready;
	batch_t rand_batch;
	logic trig_valid;
	logic trig_ready;
	batch_t trig_batch;
	logic pwl_valid;
	logic pwl_ready;
	batch_t pwl_batch;

	dac_cmd_decoder i_decoder (
		.dac_clk      (dac_clk),
		.rst          (rst),
		.fresh_bits   (fresh_bits),
		.read_resps   (read_resps),
		.halt         (halt),
		.pwl_done     (pwl_done),
		.dac_intf_rdy (dac_intf_rdy),
		.mode         (mode),
		.seeds        (seeds),
		.load_seeds   (load_seeds),
		.trig_restart (trig_restart),
		.pwl_start    (pwl_start)
	);

	// ####################
	// Generators
	// ####################
	rand_batch_gen i_rand_gen (
		.dac_clk    (dac_clk),
		.rst        (rst),
		.seeds      (seeds),
		.load_seeds (load_seeds),
		.gen_valid  (rand_valid),
		.gen_ready  (rand_ready),
		.batch      (rand_batch)
	);

	trig_batch_gen i_trig_gen (
		.dac_clk      (dac_clk),
		.rst          (rst),
		.trig_restart (trig_restart),
		.gen_valid    (trig_valid),
		.gen_ready    (trig_ready),
		.batch        (trig_batch)
	);

	pwl_batch_gen i_pwl_gen (
		.dac_clk   (dac_clk),
		.rst       (rst),
		.pwl_start (pwl_start),
		.dma_valid (dma_valid),
		.dma_data  (dma_data),
		.dma_last  (dma_last),
		.dma_ready (dma_ready),
		.gen_valid (pwl_valid),
		.gen_ready (pwl_ready),
		.batch     (pwl_batch),
		.pwl_done  (pwl_done)
	);

	batch_output_stage i_out_stage (
		.dac_clk         (dac_clk),
		.rst             (rst),
		.mode            (mode),
		.rand_valid      (rand_valid),
		.rand_ready      (rand_ready),
		.rand_batch      (rand_batch),
		.trig_valid      (trig_valid),
		.trig_ready      (trig_ready),
		.trig_batch      (trig_batch),
		.pwl_valid       (pwl_valid),
		.pwl_ready       (pwl_ready),
		.pwl_batch       (pwl_batch),
		.scale_factor    (scale_factor),
		.dac0_rdy        (dac0_rdy),
		.dac_batch       (dac_batch),
		.valid_dac_batch (valid_dac_batch)
	);

endmodule

//--- tb/dac_intf_tb.sv
`include "dac_config.svh"

module dac_intf_tb
	import dac_types_pkg::*;
	import dac_mode_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LIMIT = 400; // Cycles allowed per wait
	localparam logic [31:0] SEED = 32'hb676;

	logic dac_clk;
	logic rst;
	logic [`MEM_SIZE-1:0] fresh_bits;
	sample_t [`MEM_SIZE-1:0] read_resps;
	scale_t scale_factor;
	logic halt;
	logic dac0_rdy;
	logic dma_valid;
	dma_word_t dma_data;
	logic dma_last;
	logic dma_ready;
	logic dac_intf_rdy;
	batch_t dac_batch;
	logic valid_dac_batch;

	string test_name;
	logic [31:0] rdy_lfsr;
	logic [31:0] gap_lfsr;
	int cmd_count;
	logic halt_counting;
	logic halt_quiet;
	logic init_req;
	wave_mode_e init_mode;
	sample_t seed_vals [`BATCH_SIZE];
	dma_word_t pwl_words [3];

	// Reference model state, advanced on accepted batches
	wave_mode_e model_mode;
	sample_t trig_base;
	sample_t rand_lanes [`BATCH_SIZE];
	int pwl_idx;
	sample_t pwl_cur;
	sample_t pwl_slope;
	sample_t pwl_left; // Batches left in the current segment
	int accepted_total;
	int ack_count;
	int post_halt_accepts;
	sample_t [`BATCH_SIZE-1:0] exp_lanes;
	logic accept;
	logic pwl_finished;

	dac_intf i_dut (.*);

	function automatic logic [31:0] lfsr_advance(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	function automatic sample_t lane_lfsr_next(sample_t s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic sample_t word_start(dma_word_t w);
		return w[`DMA_DATA_WIDTH-1 -: `DATA_WIDTH];
	endfunction

	function automatic sample_t word_slope(dma_word_t w);
		return w[2*`DATA_WIDTH-1 -: `DATA_WIDTH];
	endfunction

	// A zero length plays one batch
	function automatic sample_t word_length(dma_word_t w);
		return (w[`DATA_WIDTH-1:0] == '0) ? sample_t'(1) : w[`DATA_WIDTH-1:0];
	endfunction

	task automatic report_mismatch(string name, batch_t expected, batch_t actual);
		$display("Error: %s expected %h actual %h", name, expected, actual);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(string what);
		$display("%s: %s", test_name, what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	initial begin
		dac_clk = 1'b0;
		forever #5 dac_clk = ~dac_clk;
	end

	// Random back-pressure from the DAC side
	initial begin
		rdy_lfsr = SEED;
		dac0_rdy = 1'b0;
		forever begin
			@(posedge dac_clk);
			#1;
			dac0_rdy = rdy_lfsr[0];
			rdy_lfsr = lfsr_advance(rdy_lfsr);
		end
	end

	// ####################
	// Reference models
	// ####################
	assign accept = valid_dac_batch && dac0_rdy;
	assign pwl_finished = (model_mode == MODE_PWL) && (pwl_idx == 3);

	always_comb begin : model_lanes
		sample_t lane;
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			case (model_mode)
				MODE_TRIG: lane = trig_base + sample_t'(i);
				MODE_RAND: lane = rand_lanes[i];
				MODE_PWL:  lane = pwl_cur + sample_t'(i) * pwl_slope;
				default:   lane = '0;
			endcase
			exp_lanes[i] = lane >> scale_factor;
		end
	end

	always @(posedge dac_clk) begin
		if (rst) begin
			model_mode <= MODE_IDLE;
			accepted_total <= 0;
			ack_count <= 0;
			post_halt_accepts <= 0;
		end else begin
			if (accept) accepted_total <= accepted_total + 1;
			if (dac_intf_rdy) ack_count <= ack_count + 1;
			if (!halt_counting) post_halt_accepts <= 0;
			else if (accept) post_halt_accepts <= post_halt_accepts + 1;
			if (init_req) begin
				model_mode <= init_mode;
				trig_base <= '0;
				pwl_idx <= 0;
				pwl_cur <= word_start(pwl_words[0]);
				pwl_slope <= word_slope(pwl_words[0]);
				pwl_left <= word_length(pwl_words[0]);
				for (int i = 0; i < `BATCH_SIZE; i++) begin
					rand_lanes[i] <= (seed_vals[i] == '0) ? sample_t'(1) : seed_vals[i];
				end
			end else if (accept) begin
				case (model_mode)
					MODE_TRIG: trig_base <= trig_base + sample_t'(`BATCH_SIZE);
					MODE_RAND: begin
						for (int i = 0; i < `BATCH_SIZE; i++) begin
							rand_lanes[i] <= lane_lfsr_next(rand_lanes[i]);
						end
					end
					MODE_PWL: begin
						if (pwl_left == sample_t'(1)) begin
							pwl_idx <= pwl_idx + 1;
							if (pwl_idx < 2) begin // Next segment
								pwl_cur <= word_start(pwl_words[pwl_idx + 1]);
								pwl_slope <= word_slope(pwl_words[pwl_idx + 1]);
								pwl_left <= word_length(pwl_words[pwl_idx + 1]);
							end
						end else begin
							pwl_cur <= pwl_cur + sample_t'(`BATCH_SIZE) * pwl_slope;
							pwl_left <= pwl_left - sample_t'(1);
						end
					end
					default: ;
				endcase
			end
		end
	end

	// ####################
	// Checks
	// ####################
	a_reset_idle: assert property (@(posedge dac_clk)
		rst |=> (!valid_dac_batch && !dac_intf_rdy && !dma_ready))
		else report_failure("outputs not idle after reset");

	a_one_ack: assert property (@(posedge dac_clk) disable iff (rst)
		dac_intf_rdy |-> (ack_count < cmd_count))
		else report_failure("dac_intf_rdy pulsed more than once for a command");

	a_batch_value: assert property (@(posedge dac_clk) disable iff (rst)
		accept |-> (model_mode != MODE_IDLE && dac_batch == exp_lanes))
		else report_mismatch(test_name, $sampled(exp_lanes), $sampled(dac_batch));

	a_pwl_quiet: assert property (@(posedge dac_clk) disable iff (rst)
		pwl_finished |-> !valid_dac_batch)
		else report_failure("valid_dac_batch high after the last PWL segment");

	a_halt_one: assert property (@(posedge dac_clk) disable iff (rst)
		(halt_counting && accept) |-> (post_halt_accepts == 0))
		else report_failure("more than one batch accepted after halt");

	a_halt_quiet: assert property (@(posedge dac_clk) disable iff (rst)
		halt_quiet |-> !valid_dac_batch)
		else report_failure("valid_dac_batch high while halted");

	task automatic init_model(wave_mode_e m);
		init_mode = m;
		init_req = 1'b1;
		@(posedge dac_clk);
		#1;
		init_req = 1'b0;
	endtask

	task automatic send_cmd(int id, sample_t data);
		int waited;
		waited = 0;
		fresh_bits[id] = 1'b1;
		read_resps[id] = data;
		cmd_count++;
		while (!dac_intf_rdy && waited < LIMIT) begin
			@(posedge dac_clk);
			#1;
			waited++;
		end
		if (!dac_intf_rdy) begin
			report_failure($sformatf("no dac_intf_rdy for command %0d", id));
		end else begin
			@(posedge dac_clk); // Ack edge, the flag drops after it
			#1;
			fresh_bits[id] = 1'b0;
		end
	endtask

	task automatic send_dma(dma_word_t w, logic last);
		int gap;
		int waited;
		gap = 0;
		repeat (2) begin
			gap = gap * 2 + int'(gap_lfsr[0]);
			gap_lfsr = lfsr_advance(gap_lfsr);
		end
		repeat (gap) begin
			@(posedge dac_clk);
			#1;
		end
		dma_valid = 1'b1;
		dma_data = w;
		dma_last = last;
		waited = 0;
		while (!dma_ready && waited < LIMIT) begin
			@(posedge dac_clk);
			#1;
			waited++;
		end
		if (!dma_ready) begin
			report_failure("DMA word was never taken");
		end else begin
			@(posedge dac_clk); // Handshake edge
			#1;
			dma_valid = 1'b0;
			dma_last = 1'b0;
		end
	endtask

	task automatic wait_accepts(int n);
		int target;
		int waited;
		target = accepted_total + n;
		waited = 0;
		while (accepted_total < target && waited < LIMIT) begin
			@(posedge dac_clk);
			#1;
			waited++;
		end
		if (accepted_total < target) report_failure("accepted batches stopped");
	endtask

	task automatic wait_pwl_end();
		int waited;
		waited = 0;
		while (!pwl_finished && waited < LIMIT) begin
			@(posedge dac_clk);
			#1;
			waited++;
		end
		if (!pwl_finished) report_failure("PWL segments did not all play");
	endtask

	// At most one batch drains, then the output stays quiet
	task automatic stop_output();
		int waited;
		halt = 1'b1;
		@(posedge dac_clk);
		#1;
		halt_counting = 1'b1;
		waited = 0;
		while (valid_dac_batch && waited < LIMIT) begin
			@(posedge dac_clk);
			#1;
			waited++;
		end
		if (valid_dac_batch) begin
			report_failure("held batch never left after halt");
		end else begin
			halt_quiet = 1'b1;
			repeat (50) begin
				@(posedge dac_clk);
				#1;
			end
			halt_quiet = 1'b0;
			halt_counting = 1'b0;
			halt = 1'b0;
		end
	endtask

	initial begin
		rst = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		scale_factor = '0;
		halt = 1'b0;
		dma_valid = 1'b0;
		dma_data = '0;
		dma_last = 1'b0;
		gap_lfsr = SEED;
		cmd_count = 0;
		halt_counting = 1'b0;
		halt_quiet = 1'b0;
		init_req = 1'b0;
		init_mode = MODE_IDLE;
		test_name = "reset";
		seed_vals = '{16'h1234, 16'h0000, 16'hACE1, 16'hFFFF,
			16'h0001, 16'h8000, 16'h5A5A, 16'hBEEF};
		pwl_words = '{{16'h1000, 16'h0011, 16'd3},
			{16'h8000, 16'hFFF6, 16'd0},
			{16'h0040, 16'h0100, 16'd2}};
		repeat (4) @(posedge dac_clk);
		#1;
		rst = 1'b0;

		test_name = "trig_ramp";
		init_model(MODE_TRIG);
		send_cmd(`TRIG_WAVE_ID, '0);
		wait_accepts(40);
		stop_output();

		test_name = "rand_lfsr";
		init_model(MODE_RAND);
		for (int i = 0; i < `BATCH_SIZE; i++) begin
			send_cmd(`PS_SEED_BASE_ID + i, seed_vals[i]);
		end
		send_cmd(`PS_SEED_VALID_ID, sample_t'(1));
		wait_accepts(40);
		stop_output();

		test_name = "pwl_scaled";
		scale_factor = scale_t'(4);
		init_model(MODE_PWL);
		send_cmd(`RUN_PWL_ID, '0);
		for (int i = 0; i < 3; i++) begin
			send_dma(pwl_words[i], i == 2);
		end
		wait_pwl_end();
		repeat (30) @(posedge dac_clk);
		#1;

		// Long segment so halt lands mid-run
		test_name = "halt";
		scale_factor = scale_t'(2);
		pwl_words[0] = {16'h0200, 16'h0007, 16'd40};
		init_model(MODE_PWL);
		send_cmd(`RUN_PWL_ID, '0);
		send_dma(pwl_words[0], 1'b1);
		wait_accepts(10);
		stop_output();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- dac_intf.f
+incdir+verilog
verilog/dac_types_pkg.sv
verilog/dac_mode_pkg.sv
verilog/dac_cmd_decoder.sv
verilog/rand_batch_gen.sv
verilog/trig_batch_gen.sv
verilog/pwl_batch_gen.sv
verilog/batch_output_stage.sv
verilog/dac_intf.sv
tb/dac_intf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DAC interface testbench with Verilator.
# The run passes only if the log holds the pass message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dac_intf_tb -f dac_intf.f -o dac_intf_sim \
	&& ./obj_dir/dac_intf_sim 2>&1 | tee sim.log

grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
